// File: src/pref_pkg.sv
// l2 prefetch engine shared definitions
// address geometry, confidence limits, request enums and predictor structs
`default_nettype none

package pref_pkg;

    localparam int ADDR_WIDTH = 32;
    // two bits of word offset plus three of l2 line size
    localparam int LINE_OFFSET = 5;
    localparam int LINE_WIDTH = ADDR_WIDTH - LINE_OFFSET;

    // 2-bit saturating confidence
    localparam logic [1:0] CONF_MAX = 2'd3;
    localparam logic [1:0] CONF_ISSUE = 2'd2;

    typedef enum logic [1:0] {
        IDLE = 2'd0,
        REQ  = 2'd1,
        WAIT = 2'd2
    } req_state_e;

    typedef enum logic {
        INST = 1'b0,
        DATA = 1'b1
    } pref_kind_e;

    // one data cache access at line granularity
    typedef struct packed {
        logic [LINE_WIDTH-1:0] pc_line;
        logic [LINE_WIDTH-1:0] addr_line;
    } data_access_t;

    // candidate offered by a predictor
    typedef struct packed {
        logic                  valid;
        logic [LINE_WIDTH-1:0] line;
    } pref_cand_t;

    // completion feedback to one slot
    typedef struct packed {
        logic strobe;
        logic hit;
    } pref_fb_t;

endpackage

`default_nettype wire

// File: src/pref_stream_dispatch.sv
// data stream dispatcher
// folds load and anneal PCs into a slot index, registers one-hot strobes and the access
`timescale 1ns/1ps
`default_nettype none

module pref_stream_dispatch #(
    parameter int NUM_STREAMS = 4
) (
    input  logic                                   clk,
    input  logic                                   rstn,
    input  logic                                   access_valid,
    input  pref_pkg::data_access_t                 access,
    input  logic                                   anneal_valid,
    input  logic [pref_pkg::LINE_WIDTH-1:0]        anneal_pc_line,
    output pref_pkg::data_access_t                 slot_access [NUM_STREAMS],
    output logic [NUM_STREAMS-1:0]                 slot_strobe,
    output logic [NUM_STREAMS-1:0]                 slot_anneal
);

    localparam int IDX_W = (NUM_STREAMS > 1) ? $clog2(NUM_STREAMS) : 1;

    logic [IDX_W-1:0] access_idx;
    logic [IDX_W-1:0] anneal_idx;

    // low index bits xor the next group up
    function automatic logic [IDX_W-1:0] fold_pc(input logic [pref_pkg::LINE_WIDTH-1:0] pc_line);
        fold_pc = pc_line[IDX_W-1:0] ^ pc_line[2*IDX_W-1:IDX_W];
    endfunction

    assign access_idx = fold_pc(access.pc_line);
    assign anneal_idx = fold_pc(anneal_pc_line);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            slot_strobe <= '0;
            slot_anneal <= '0;
        end else begin
            slot_strobe <= '0;
            slot_anneal <= '0;
            if (access_valid) begin
                slot_strobe[access_idx] <= 1'b1;
            end
            if (anneal_valid) begin
                slot_anneal[anneal_idx] <= 1'b1;
            end
        end
    end

    // each slot keeps its most recent access
    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_STREAMS; i++) begin
            if (access_valid && access_idx == IDX_W'(i)) begin
                slot_access[i] <= access;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/pref_stride_slot.sv
// stride tracking slot
// learns a line stride per stream and offers the next line once confident
`timescale 1ns/1ps
`default_nettype none

module pref_stride_slot (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   access_strobe,
    input  pref_pkg::data_access_t access,
    input  logic                   anneal,
    input  logic                   grant,
    input  pref_pkg::pref_fb_t     fb,
    output pref_pkg::pref_cand_t   cand
);

    logic [pref_pkg::LINE_WIDTH-1:0] last_line;
    logic [pref_pkg::LINE_WIDTH-1:0] stride;
    logic [pref_pkg::LINE_WIDTH-1:0] delta;
    logic [1:0]                      conf;
    logic [1:0]                      conf_next;
    logic                            match;
    logic                            fb_hit;
    logic                            backoff;
    logic                            issue;

    assign delta  = access.addr_line - last_line;
    assign match  = (delta != '0) && (delta == stride);
    assign fb_hit = fb.strobe && fb.hit;

    always_comb begin
        conf_next = conf;
        if (access_strobe) begin
            if (!match) begin
                conf_next = '0;
            end else if (!backoff && conf != pref_pkg::CONF_MAX) begin
                conf_next = conf + 2'd1;
            end
        end
        // line was already in l2 so back off
        if (fb_hit && conf_next != '0) begin
            conf_next = conf_next - 2'd1;
        end
    end

    assign issue = access_strobe && (conf_next >= pref_pkg::CONF_ISSUE);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            last_line <= '0;
            stride    <= '0;
            conf      <= '0;
            backoff   <= 1'b0;
            cand      <= '0;
        end else begin
            conf <= conf_next;

            // a hit also holds off the next rise
            if (fb_hit) begin
                backoff <= 1'b1;
            end else if (access_strobe) begin
                backoff <= 1'b0;
            end

            if (grant) begin
                cand.valid <= 1'b0;
            end

            if (access_strobe) begin
                last_line <= access.addr_line;
                if (!match) begin
                    stride <= delta;
                end
                // latest access decides the candidate
                cand.valid <= issue;
                // on a match delta equals the stored stride
                cand.line  <= access.addr_line + delta;
            end

            if (anneal) begin
                conf       <= '0;
                cand.valid <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/pref_next_line.sv
// instruction next-line predictor
// offers fetch line plus one, skipping repeated fetches of the same line
`timescale 1ns/1ps
`default_nettype none

module pref_next_line (
    input  logic                            clk,
    input  logic                            rstn,
    input  logic                            fetch_valid,
    input  logic [pref_pkg::LINE_WIDTH-1:0] fetch_line,
    input  logic                            anneal,
    input  logic                            grant,
    output pref_pkg::pref_cand_t            cand
);

    logic [pref_pkg::LINE_WIDTH-1:0] last_line;
    logic                            last_valid;
    logic                            new_line;

    assign new_line = fetch_valid && (!last_valid || fetch_line != last_line);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            last_valid <= 1'b0;
            cand       <= '0;
        end else begin
            if (grant || anneal) begin
                cand.valid <= 1'b0;
            end
            if (new_line) begin
                cand.valid <= 1'b1;
                cand.line  <= fetch_line + 1'b1;
            end
            if (fetch_valid) begin
                last_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_valid) begin
            last_line <= fetch_line;
        end
    end

endmodule

`default_nettype wire

// File: src/pref_issue.sv
// prefetch issue unit
// fixed-priority pick, L2 request FSM and completion feedback to the owning slot
`timescale 1ns/1ps
`default_nettype none

module pref_issue #(
    parameter int NUM_STREAMS = 4
) (
    input  logic                            clk,
    input  logic                            rstn,
    input  pref_pkg::pref_cand_t            data_cand [NUM_STREAMS],
    input  pref_pkg::pref_cand_t            inst_cand,
    output logic [NUM_STREAMS-1:0]          data_grant,
    output logic                            inst_grant,
    output pref_pkg::pref_fb_t              data_fb [NUM_STREAMS],
    input  logic                            addr_ok,
    input  logic                            complete,
    input  logic                            l2_hit,
    output logic                            req_pref_l2cache,
    output pref_pkg::pref_kind_e            type_pref_l2cache,
    output logic [pref_pkg::ADDR_WIDTH-1:0] addr_pref_l2cache
);

    localparam int IDX_W = (NUM_STREAMS > 1) ? $clog2(NUM_STREAMS) : 1;

    pref_pkg::req_state_e            state;
    pref_pkg::req_state_e            state_next;
    logic                            data_any;
    logic [IDX_W-1:0]                data_idx;
    logic                            pick_valid;
    pref_pkg::pref_kind_e            pick_kind;
    logic [pref_pkg::LINE_WIDTH-1:0] pick_line;
    logic [IDX_W-1:0]                owner_idx;
    logic                            start;
    logic                            done;

    // scan downward so the lowest valid index is left
    always_comb begin
        data_any = 1'b0;
        data_idx = '0;
        for (int i = NUM_STREAMS - 1; i >= 0; i--) begin
            if (data_cand[i].valid) begin
                data_any = 1'b1;
                data_idx = IDX_W'(i);
            end
        end
    end

    always_comb begin
        if (data_any) begin
            pick_kind = pref_pkg::DATA;
            pick_line = data_cand[data_idx].line;
        end else begin
            pick_kind = pref_pkg::INST;
            pick_line = inst_cand.line;
        end
    end

    assign pick_valid       = data_any || inst_cand.valid;
    assign start            = (state == pref_pkg::IDLE) && pick_valid;
    assign req_pref_l2cache = (state == pref_pkg::REQ) || (state == pref_pkg::WAIT);
    assign done             = req_pref_l2cache && complete;

    always_comb begin
        data_grant = '0;
        if (start && data_any) begin
            data_grant[data_idx] = 1'b1;
        end
    end

    assign inst_grant = start && !data_any;

    always_comb begin
        case (state)
            pref_pkg::IDLE: state_next = start ? pref_pkg::REQ : pref_pkg::IDLE;
            pref_pkg::REQ: begin
                if (addr_ok) begin
                    state_next = complete ? pref_pkg::IDLE : pref_pkg::WAIT;
                end else begin
                    state_next = pref_pkg::REQ;
                end
            end
            pref_pkg::WAIT: state_next = complete ? pref_pkg::IDLE : pref_pkg::WAIT;
            default: state_next = pref_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state             <= pref_pkg::IDLE;
            type_pref_l2cache <= pref_pkg::INST;
            addr_pref_l2cache <= '0;
        end else begin
            state <= state_next;
            // request fields only change while idle
            if (state == pref_pkg::IDLE) begin
                if (start) begin
                    type_pref_l2cache <= pick_kind;
                    addr_pref_l2cache <= {pick_line, {pref_pkg::LINE_OFFSET{1'b0}}};
                end else begin
                    type_pref_l2cache <= pref_pkg::INST;
                    addr_pref_l2cache <= '0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            owner_idx <= data_idx;
        end
    end

    // feedback lands one cycle after complete
    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < NUM_STREAMS; i++) begin
                data_fb[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_STREAMS; i++) begin
                data_fb[i].strobe <= done && (type_pref_l2cache == pref_pkg::DATA)
                                     && (owner_idx == IDX_W'(i));
                data_fb[i].hit    <= l2_hit;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/prefetch_top.sv
// l2 prefetch engine top level
// stride slots for loads and a next-line predictor for fetches feed one L2 request port
`timescale 1ns/1ps
`default_nettype none

module prefetch_top #(
    parameter int NUM_STREAMS = 4
) (
    input  logic                            clk,
    input  logic                            rstn,
    input  logic                            pdc_pref_valid,
    input  logic [pref_pkg::ADDR_WIDTH-1:0] pdc_pref_addr,
    input  logic                            dcache_pref_valid,
    input  logic [pref_pkg::ADDR_WIDTH-1:0] dcache_pref_addr,
    input  logic [pref_pkg::ADDR_WIDTH-1:0] dcache_pref_pc,
    input  logic                            anneal_unhit,
    input  pref_pkg::pref_kind_e            anneal_type,
    input  logic [pref_pkg::ADDR_WIDTH-1:0] anneal_addr,
    input  logic [pref_pkg::ADDR_WIDTH-1:0] anneal_pc,
    input  logic                            addr_ok,
    input  logic                            complete,
    input  logic                            l2_hit,
    output logic                            req_pref_l2cache,
    output pref_pkg::pref_kind_e            type_pref_l2cache,
    output logic [pref_pkg::ADDR_WIDTH-1:0] addr_pref_l2cache
);

    pref_pkg::data_access_t dcache_access;
    pref_pkg::data_access_t slot_access [NUM_STREAMS];
    logic [NUM_STREAMS-1:0] slot_strobe;
    logic [NUM_STREAMS-1:0] slot_anneal;
    pref_pkg::pref_cand_t   data_cand [NUM_STREAMS];
    pref_pkg::pref_fb_t     data_fb [NUM_STREAMS];
    logic [NUM_STREAMS-1:0] data_grant;
    pref_pkg::pref_cand_t   inst_cand;
    logic                   inst_grant;
    logic                   data_anneal;
    logic                   inst_anneal;

    assign dcache_access.pc_line   = dcache_pref_pc[pref_pkg::ADDR_WIDTH-1:pref_pkg::LINE_OFFSET];
    assign dcache_access.addr_line = dcache_pref_addr[pref_pkg::ADDR_WIDTH-1:pref_pkg::LINE_OFFSET];

    assign data_anneal = anneal_unhit && (anneal_type == pref_pkg::DATA);
    // an unused instruction line only drops the matching pending offer
    assign inst_anneal = anneal_unhit && (anneal_type == pref_pkg::INST)
                         && (anneal_addr[pref_pkg::ADDR_WIDTH-1:pref_pkg::LINE_OFFSET]
                             == inst_cand.line);

    pref_stream_dispatch #(
        .NUM_STREAMS(NUM_STREAMS)
    ) u_dispatch (
        .clk           (clk),
        .rstn          (rstn),
        .access_valid  (dcache_pref_valid),
        .access        (dcache_access),
        .anneal_valid  (data_anneal),
        .anneal_pc_line(anneal_pc[pref_pkg::ADDR_WIDTH-1:pref_pkg::LINE_OFFSET]),
        .slot_access   (slot_access),
        .slot_strobe   (slot_strobe),
        .slot_anneal   (slot_anneal)
    );

    for (genvar i = 0; i < NUM_STREAMS; i++) begin : g_slot
        pref_stride_slot u_slot (
            .clk          (clk),
            .rstn         (rstn),
            .access_strobe(slot_strobe[i]),
            .access       (slot_access[i]),
            .anneal       (slot_anneal[i]),
            .grant        (data_grant[i]),
            .fb           (data_fb[i]),
            .cand         (data_cand[i])
        );
    end

    pref_next_line u_next_line (
        .clk        (clk),
        .rstn       (rstn),
        .fetch_valid(pdc_pref_valid),
        .fetch_line (pdc_pref_addr[pref_pkg::ADDR_WIDTH-1:pref_pkg::LINE_OFFSET]),
        .anneal     (inst_anneal),
        .grant      (inst_grant),
        .cand       (inst_cand)
    );

    pref_issue #(
        .NUM_STREAMS(NUM_STREAMS)
    ) u_issue (
        .clk              (clk),
        .rstn             (rstn),
        .data_cand        (data_cand),
        .inst_cand        (inst_cand),
        .data_grant       (data_grant),
        .inst_grant       (inst_grant),
        .data_fb          (data_fb),
        .addr_ok          (addr_ok),
        .complete         (complete),
        .l2_hit           (l2_hit),
        .req_pref_l2cache (req_pref_l2cache),
        .type_pref_l2cache(type_pref_l2cache),
        .addr_pref_l2cache(addr_pref_l2cache)
    );

endmodule

`default_nettype wire

// File: sim/l2_responder.sv
// behavioral L2 responder
// answers each prefetch request with addr_ok and complete after set delays
`timescale 1ns/1ps
`default_nettype none

module l2_responder (
    input  logic clk,
    input  logic rstn,
    input  logic req,
    input  int   ok_delay,
    input  int   done_delay,
    input  logic hit_value,
    output logic addr_ok,
    output logic complete,
    output logic l2_hit
);

    int cycles;

    initial begin
        cycles   = 0;
        addr_ok  = 1'b0;
        complete = 1'b0;
        l2_hit   = 1'b0;
    end

    // counts falling edges of an open request
    always @(negedge clk) begin
        if (!rstn || !req) begin
            cycles = 0;
            addr_ok  <= 1'b0;
            complete <= 1'b0;
            l2_hit   <= 1'b0;
        end else begin
            cycles = cycles + 1;
            addr_ok  <= (cycles >= ok_delay);
            complete <= (cycles >= done_delay);
            l2_hit   <= (cycles >= done_delay) && hit_value;
        end
    end

endmodule

`default_nettype wire

// File: sim/tb_prefetch.sv
// l2 prefetch engine testbench
// drives load, fetch and anneal streams and checks the L2 request port
`timescale 1ns/1ps
`default_nettype none

module tb_prefetch;

    localparam int LW          = pref_pkg::LINE_WIDTH;
    localparam int LO          = pref_pkg::LINE_OFFSET;
    localparam int REQ_TIMEOUT = 100;
    localparam int QUIET_WAIT  = 40;
    localparam int MAX_CYCLES  = 3000;

    logic                 clk;
    logic                 rstn;
    logic                 pdc_pref_valid;
    logic [31:0]          pdc_pref_addr;
    logic                 dcache_pref_valid;
    logic [31:0]          dcache_pref_addr;
    logic [31:0]          dcache_pref_pc;
    logic                 anneal_unhit;
    pref_pkg::pref_kind_e anneal_type;
    logic [31:0]          anneal_addr;
    logic [31:0]          anneal_pc;
    logic                 addr_ok;
    logic                 complete;
    logic                 l2_hit;
    logic                 req_pref_l2cache;
    pref_pkg::pref_kind_e type_pref_l2cache;
    logic [31:0]          addr_pref_l2cache;

    int          ok_delay;
    int          done_delay;
    logic        hit_value;
    int          seed;
    int          errors;
    int          tests_run;
    int          test_errors;
    logic [31:0] req_kinds [$];
    logic [31:0] req_addrs [$];
    logic        req_prev;
    logic        req_busy;
    logic        complete_seen;
    logic [31:0] addr_prev;
    logic [31:0] type_prev;
    int          high_len;

    prefetch_top #(
        .NUM_STREAMS(4)
    ) u_prefetch_top (
        .clk              (clk),
        .rstn             (rstn),
        .pdc_pref_valid   (pdc_pref_valid),
        .pdc_pref_addr    (pdc_pref_addr),
        .dcache_pref_valid(dcache_pref_valid),
        .dcache_pref_addr (dcache_pref_addr),
        .dcache_pref_pc   (dcache_pref_pc),
        .anneal_unhit     (anneal_unhit),
        .anneal_type      (anneal_type),
        .anneal_addr      (anneal_addr),
        .anneal_pc        (anneal_pc),
        .addr_ok          (addr_ok),
        .complete         (complete),
        .l2_hit           (l2_hit),
        .req_pref_l2cache (req_pref_l2cache),
        .type_pref_l2cache(type_pref_l2cache),
        .addr_pref_l2cache(addr_pref_l2cache)
    );

    l2_responder u_l2_responder (
        .clk       (clk),
        .rstn      (rstn),
        .req       (req_pref_l2cache),
        .ok_delay  (ok_delay),
        .done_delay(done_delay),
        .hit_value (hit_value),
        .addr_ok   (addr_ok),
        .complete  (complete),
        .l2_hit    (l2_hit)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    task automatic check_equal(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        assert (actual === expected) else begin
            $display("Fail t=%0t %s expected %h got %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    function automatic logic [31:0] line_addr(input logic [LW-1:0] line);
        line_addr = {line, {LO{1'b0}}};
    endfunction

    function automatic logic [LW-1:0] line_at_step(input logic [LW-1:0] base,
                                                   input logic [LW-1:0] stride,
                                                   input int step);
        line_at_step = base + stride * LW'(step);
    endfunction

    function automatic logic [LW-1:0] random_line();
        random_line = LW'($random(seed));
    endfunction

    function automatic logic [LW-1:0] random_stride();
        random_stride = LW'(($random(seed) & 15) + 1);
    endfunction

    function automatic void clear_strobes();
        pdc_pref_valid    = 1'b0;
        dcache_pref_valid = 1'b0;
        anneal_unhit      = 1'b0;
    endfunction

    task automatic drive_load(input logic [LW-1:0] pc_line, input logic [LW-1:0] addr_line);
        @(negedge clk);
        clear_strobes();
        dcache_pref_valid = 1'b1;
        dcache_pref_pc    = line_addr(pc_line);
        dcache_pref_addr  = line_addr(addr_line);
    endtask

    task automatic drive_fetch(input logic [LW-1:0] line);
        @(negedge clk);
        clear_strobes();
        pdc_pref_valid = 1'b1;
        pdc_pref_addr  = line_addr(line);
    endtask

    task automatic drive_data_anneal(input logic [LW-1:0] pc_line);
        @(negedge clk);
        clear_strobes();
        anneal_unhit = 1'b1;
        anneal_type  = pref_pkg::DATA;
        anneal_pc    = line_addr(pc_line);
    endtask

    task automatic drive_idle();
        @(negedge clk);
        clear_strobes();
    endtask

    // four accesses bring a stride to confidence 2
    task automatic train_slot(input logic [LW-1:0] pc_line, input logic [LW-1:0] base,
                              input logic [LW-1:0] stride);
        for (int i = 0; i < 4; i++) begin
            drive_load(pc_line, line_at_step(base, stride, i));
        end
    endtask

    task automatic expect_request(input pref_pkg::pref_kind_e kind, input logic [31:0] addr);
        int waited;
        waited = 0;
        while (req_kinds.size() == 0 && waited < REQ_TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        assert (req_kinds.size() != 0) else begin
            $display("no request to %h within %0d cycles", addr, REQ_TIMEOUT);
            errors++;
        end
        if (req_kinds.size() != 0) begin
            check_equal("type_pref_l2cache", req_kinds.pop_front(), kind);
            check_equal("addr_pref_l2cache", req_addrs.pop_front(), addr);
        end
    endtask

    task automatic expect_none();
        for (int i = 0; i < QUIET_WAIT; i++) begin
            @(posedge clk);
        end
        assert (req_kinds.size() == 0) else begin
            $display("unexpected request to %h at %0t", req_addrs[0], $time);
            errors++;
        end
        req_kinds.delete();
        req_addrs.delete();
    endtask

    task automatic wait_idle();
        int waited;
        waited = 0;
        while (req_busy && waited < REQ_TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        assert (!req_busy) else begin
            $display("request still open after %0d cycles", REQ_TIMEOUT);
            errors++;
        end
        @(negedge clk);
    endtask

    task automatic end_test(input string name);
        $display("test %0d %s errors %0d", tests_run + 1, name, errors - test_errors);
        tests_run++;
        test_errors = errors;
    endtask

    always @(posedge clk) begin
        complete_seen <= complete;
    end

    // request protocol monitor on the falling edge
    always @(negedge clk) begin
        if (req_prev) begin
            check_equal("req_pref_l2cache", req_pref_l2cache, !complete_seen);
        end
        if (req_pref_l2cache && !req_prev) begin
            req_kinds.push_back(type_pref_l2cache);
            req_addrs.push_back(addr_pref_l2cache);
            high_len = 1;
        end else if (req_pref_l2cache) begin
            high_len++;
            check_equal("addr_pref_l2cache", addr_pref_l2cache, addr_prev);
            check_equal("type_pref_l2cache", type_pref_l2cache, type_prev);
        end
        if (!req_pref_l2cache && req_prev) begin
            check_equal("req_pref_l2cache cycles", high_len, done_delay);
        end
        if (req_pref_l2cache) begin
            check_equal("addr_pref_l2cache offset", addr_pref_l2cache[LO-1:0], '0);
        end
        req_prev  = req_pref_l2cache;
        req_busy  = req_pref_l2cache;
        addr_prev = addr_pref_l2cache;
        type_prev = type_pref_l2cache;
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("run did not finish within %0d cycles", MAX_CYCLES);
        $display("Regression failed");
        $finish;
    end

    initial begin : main
        logic [LW-1:0] base;
        logic [LW-1:0] stride;
        logic [LW-1:0] fetch_line;
        seed = 32'h75ba8dd4;
        errors = 0;
        tests_run = 0;
        test_errors = 0;
        req_prev = 1'b0;
        req_busy = 1'b0;
        complete_seen = 1'b0;
        high_len = 0;
        ok_delay = 1;
        done_delay = 2;
        hit_value = 1'b0;
        rstn = 1'b0;
        clear_strobes();
        pdc_pref_addr = '0;
        dcache_pref_addr = '0;
        dcache_pref_pc = '0;
        anneal_type = pref_pkg::INST;
        anneal_addr = '0;
        anneal_pc = '0;

        repeat (5) @(negedge clk);
        check_equal("req_pref_l2cache", req_pref_l2cache, 1'b0);
        rstn = 1'b1;
        for (int i = 0; i < 8; i++) begin
            @(negedge clk);
            check_equal("req_pref_l2cache", req_pref_l2cache, 1'b0);
            check_equal("type_pref_l2cache", type_pref_l2cache, 1'b0);
            check_equal("addr_pref_l2cache", addr_pref_l2cache, '0);
        end
        end_test("reset");

        // slot 1 trains fully and slot 2 sees only two matching deltas
        base = random_line();
        stride = random_stride();
        train_slot(1, base, stride);
        drive_idle();
        expect_request(pref_pkg::DATA, line_addr(line_at_step(base, stride, 4)));
        wait_idle();
        base = random_line();
        stride = random_stride();
        for (int i = 0; i < 3; i++) begin
            drive_load(2, line_at_step(base, stride, i));
        end
        drive_idle();
        expect_none();
        end_test("stride");

        fetch_line = random_line();
        drive_fetch(fetch_line);
        drive_idle();
        expect_request(pref_pkg::INST, line_addr(fetch_line + 1'b1));
        wait_idle();
        drive_fetch(fetch_line);
        drive_idle();
        expect_none();
        end_test("next_line");

        ok_delay = 6;
        done_delay = 12;
        fetch_line = random_line();
        drive_fetch(fetch_line);
        drive_idle();
        expect_request(pref_pkg::INST, line_addr(fetch_line + 1'b1));
        wait_idle();
        end_test("backpressure");

        // a long instruction request holds off both new candidates
        ok_delay = 2;
        done_delay = 24;
        fetch_line = random_line();
        drive_fetch(fetch_line);
        drive_idle();
        expect_request(pref_pkg::INST, line_addr(fetch_line + 1'b1));
        base = random_line();
        stride = random_stride();
        fetch_line = random_line();
        train_slot(3, base, stride);
        drive_fetch(fetch_line);
        drive_idle();
        expect_request(pref_pkg::DATA, line_addr(line_at_step(base, stride, 4)));
        expect_request(pref_pkg::INST, line_addr(fetch_line + 1'b1));
        wait_idle();
        ok_delay = 1;
        done_delay = 2;
        end_test("priority");

        hit_value = 1'b1;
        base = random_line();
        stride = random_stride();
        train_slot(0, base, stride);
        drive_idle();
        expect_request(pref_pkg::DATA, line_addr(line_at_step(base, stride, 4)));
        wait_idle();
        drive_load(0, line_at_step(base, stride, 4));
        drive_idle();
        expect_none();
        hit_value = 1'b0;
        base = random_line();
        stride = random_stride();
        train_slot(0, base, stride);
        drive_idle();
        expect_request(pref_pkg::DATA, line_addr(line_at_step(base, stride, 4)));
        wait_idle();
        drive_load(0, line_at_step(base, stride, 4));
        drive_idle();
        expect_request(pref_pkg::DATA, line_addr(line_at_step(base, stride, 5)));
        wait_idle();
        drive_data_anneal(0);
        drive_idle();
        drive_load(0, line_at_step(base, stride, 5));
        drive_idle();
        expect_none();
        end_test("feedback");

        $display("tests run %0d, errors %0d", tests_run, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
src/pref_pkg.sv
src/pref_stream_dispatch.sv
src/pref_stride_slot.sv
src/pref_next_line.sv
src/pref_issue.sv
src/prefetch_top.sv
sim/l2_responder.sv
sim/tb_prefetch.sv

// File: Bender.yml
package:
  name: l2_prefetch

sources:
  - src/pref_pkg.sv
  - src/pref_stream_dispatch.sv
  - src/pref_stride_slot.sv
  - src/pref_next_line.sv
  - src/pref_issue.sv
  - src/prefetch_top.sv
  - target: simulation
    files:
      - sim/l2_responder.sv
      - sim/tb_prefetch.sv
